/* source/tdc_link_pkg.sv */
`default_nettype none

package tdc_link_pkg;

    // channel count and per-channel masks
    localparam int num_channels = 6;
    typedef logic [num_channels-1:0] chan_mask_t;

    // tdc hit payload, channel 1 in the lowest slice of the bus
    localparam int payload_bits = 32;
    typedef logic [payload_bits-1:0] payload_t;
    typedef logic [num_channels*payload_bits-1:0] hit_bus_t;

    // 16-bit words of a record
    typedef logic [15:0] chan_tag_t;
    typedef logic [15:0] marker_t;

    // hit: payload over tag; marker: code, code, tag
    typedef logic [47:0] record_t;

    // mems scan marker codes
    localparam marker_t line_code  = 16'h000D;
    localparam marker_t frame_code = 16'h000E;

    // record queue geometry
    localparam int fifo_addr_bits = 10;
    localparam int fifo_depth     = 1 << fifo_addr_bits;
    typedef logic [fifo_addr_bits-1:0] fifo_addr_t;
    typedef logic [fifo_addr_bits:0]   fifo_count_t;

    // serial line, bit period is small for simulation
    localparam int clks_per_bit     = 8;
    localparam int bytes_per_record = 6;
    localparam int bits_per_frame   = 10;
    localparam int bits_per_record  = bytes_per_record * bits_per_frame;
    typedef logic [7:0] byte_t;

    // counter widths inside the transmitter
    localparam int baud_bits = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;
    typedef logic [baud_bits-1:0]                 baud_cnt_t;
    typedef logic [$clog2(bits_per_record)-1:0]   bit_pos_t;
    typedef logic [$clog2(bits_per_frame)-1:0]    slot_t;

endpackage

`default_nettype wire

/* source/record_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module record_arbiter
    import tdc_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  chan_mask_t hit_req,
    input  chan_mask_t line_req,
    input  chan_mask_t frame_req,
    input  hit_bus_t   hit_data,
    input  logic       nearly_full,
    output chan_mask_t hit_done,
    output chan_mask_t line_done,
    output chan_mask_t frame_done,
    output logic       wr_en,
    output record_t    wr_record
);

    // one-hot winner among all 18 requests, before back-pressure
    chan_mask_t hit_grant;
    chan_mask_t line_grant;
    chan_mask_t frame_grant;
    logic       any_grant;
    record_t    next_record;

    // channel tag for a zero-based index
    function automatic chan_tag_t tag_of(input int idx);
        tag_of = chan_tag_t'(idx + 1);
    endfunction

    always_comb begin
        hit_grant   = '0;
        line_grant  = '0;
        frame_grant = '0;
        any_grant   = 1'b0;
        next_record = '0;

        // hits win over every marker, lowest channel first
        for (int i = 0; i < num_channels; i++) begin
            if (!any_grant && hit_req[i]) begin
                any_grant    = 1'b1;
                hit_grant[i] = 1'b1;
                next_record  = {hit_data[i*payload_bits +: payload_bits], tag_of(i)};
            end
        end

        // markers, walked per channel
        // line ahead of frame on the same channel
        for (int i = 0; i < num_channels; i++) begin
            if (!any_grant && line_req[i]) begin
                any_grant     = 1'b1;
                line_grant[i] = 1'b1;
                next_record   = {line_code, line_code, tag_of(i)};
            end
            if (!any_grant && frame_req[i]) begin
                any_grant      = 1'b1;
                frame_grant[i] = 1'b1;
                next_record    = {frame_code, frame_code, tag_of(i)};
            end
        end
    end

    // done pulses in the grant cycle
    // held off while the queue has one slot or less
    assign hit_done   = nearly_full ? '0 : hit_grant;
    assign line_done  = nearly_full ? '0 : line_grant;
    assign frame_done = nearly_full ? '0 : frame_grant;

    // write strobe one cycle after the done
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= any_grant && !nearly_full;
        end
    end

    // record register, only loaded on a grant
    always_ff @(posedge clk) begin
        if (any_grant && !nearly_full) begin
            wr_record <= next_record;
        end
    end

endmodule

`default_nettype wire

/* source/record_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module record_fifo
    import tdc_link_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_en,
    input  record_t wr_record,
    input  logic    take,
    output record_t head_record,
    output logic    head_valid,
    output logic    nearly_full
);

    // record storage
    record_t     mem [fifo_depth];

    // pointers wrap on their own at 2^fifo_addr_bits
    fifo_addr_t  wr_ptr;
    fifo_addr_t  rd_ptr;
    fifo_count_t count;

    logic        push;
    logic        pop;

    // guards, arbiter back-pressure already keeps push legal
    assign push = wr_en && (count != fifo_count_t'(fifo_depth));
    assign pop  = take && head_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_record;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy, unchanged on simultaneous push and pop
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // show-ahead head, no read strobe needed
    assign head_record = mem[rd_ptr];

    // status from occupancy
    assign head_valid  = (count != '0);
    assign nearly_full = (count >= fifo_count_t'(fifo_depth - 1));

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
    import tdc_link_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  record_t head_record,
    input  logic    head_valid,
    output logic    take,
    output logic    tx,
    output logic    tx_busy
);

    // bytes still to go, lowest byte next
    record_t   rec_q;
    // byte on the line, shifted out lsb first
    byte_t     cur_byte;

    baud_cnt_t baud_cnt;
    bit_pos_t  bit_cnt;
    slot_t     slot;
    slot_t     next_slot;
    logic      baud_tick;
    logic      last_bit;
    logic      next_tx;

    // pop the head as soon as the line is free
    assign take = head_valid && !tx_busy;

    assign baud_tick = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));
    assign last_bit  = (bit_cnt == bit_pos_t'(bits_per_record - 1));

    // position inside the 10-bit frame after the current one
    assign next_slot = (slot == slot_t'(bits_per_frame - 1)) ? '0 : slot + 1'b1;

    // slot 0 start, slot 9 stop, data in between
    always_comb begin
        if (next_slot == '0) begin
            next_tx = 1'b0;
        end else if (next_slot == slot_t'(bits_per_frame - 1)) begin
            next_tx = 1'b1;
        end else begin
            next_tx = cur_byte[0];
        end
    end

    // line control and counters
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            slot     <= '0;
        end else if (take) begin
            // start bit of byte 0 goes out next cycle
            tx_busy  <= 1'b1;
            tx       <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            slot     <= '0;
        end else if (tx_busy) begin
            if (!baud_tick) begin
                baud_cnt <= baud_cnt + 1'b1;
            end else begin
                baud_cnt <= '0;
                if (last_bit) begin
                    // final stop bit done, back to idle high
                    tx_busy <= 1'b0;
                    tx      <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    slot    <= next_slot;
                    tx      <= next_tx;
                end
            end
        end
    end

    // data shifters
    always_ff @(posedge clk) begin
        if (take) begin
            cur_byte <= byte_t'(head_record);
            rec_q    <= record_t'(head_record >> 8);
        end else if (tx_busy && baud_tick && !last_bit) begin
            if (next_slot == '0) begin
                // next byte, bytes go back to back
                cur_byte <= byte_t'(rec_q);
                rec_q    <= record_t'(rec_q >> 8);
            end else if (next_slot != slot_t'(bits_per_frame - 1)) begin
                cur_byte <= byte_t'(cur_byte >> 1);
            end
        end
    end

endmodule

`default_nettype wire

/* source/tdc_link_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_link_top
    import tdc_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  chan_mask_t hit_req,
    input  chan_mask_t line_req,
    input  chan_mask_t frame_req,
    input  hit_bus_t   hit_data,
    output chan_mask_t hit_done,
    output chan_mask_t line_done,
    output chan_mask_t frame_done,
    output logic       tx,
    output logic       tx_busy
);

    // arbiter to fifo
    logic    wr_en;
    record_t wr_record;
    logic    nearly_full;

    // fifo to transmitter
    record_t head_record;
    logic    head_valid;
    logic    take;

    record_arbiter u_arbiter (
        .clk         (clk),
        .rst         (rst),
        .hit_req     (hit_req),
        .line_req    (line_req),
        .frame_req   (frame_req),
        .hit_data    (hit_data),
        .nearly_full (nearly_full),
        .hit_done    (hit_done),
        .line_done   (line_done),
        .frame_done  (frame_done),
        .wr_en       (wr_en),
        .wr_record   (wr_record)
    );

    // record queue, absorbs bursts while the line drains
    record_fifo u_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_record   (wr_record),
        .take        (take),
        .head_record (head_record),
        .head_valid  (head_valid),
        .nearly_full (nearly_full)
    );

    uart_tx u_uart_tx (
        .clk         (clk),
        .rst         (rst),
        .head_record (head_record),
        .head_valid  (head_valid),
        .take        (take),
        .tx          (tx),
        .tx_busy     (tx_busy)
    );

endmodule

`default_nettype wire

/* testbench/tdc_link_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_link_tb
    import tdc_link_pkg::*;
;

    logic       clk;
    logic       rst;
    chan_mask_t hit_req;
    chan_mask_t line_req;
    chan_mask_t frame_req;
    hit_bus_t   hit_data;
    chan_mask_t hit_done;
    chan_mask_t line_done;
    chan_mask_t frame_done;
    logic       tx;
    logic       tx_busy;

    // done vectors from the last cycle as the sources saw them
    chan_mask_t last_hit_done;
    chan_mask_t last_line_done;
    chan_mask_t last_frame_done;

    record_t    exp_q[$];
    integer     seed;
    int         checks;
    int         errors;
    int         granted;
    int         decoded;

    tdc_link_top UUT (
        .clk        (clk),
        .rst        (rst),
        .hit_req    (hit_req),
        .line_req   (line_req),
        .frame_req  (frame_req),
        .hit_data   (hit_data),
        .hit_done   (hit_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // source index in priority order
    // 0..5 hits then line and frame per channel
    function automatic int source_kind(input int p);
        return (p < num_channels) ? 0 : 1 + (p - num_channels) % 2;
    endfunction

    function automatic int source_chan(input int p);
        return (p < num_channels) ? p : (p - num_channels) / 2;
    endfunction

    function automatic logic source_pending(input int p);
        chan_mask_t m;
        m = (source_kind(p) == 0) ? hit_req : (source_kind(p) == 1) ? line_req : frame_req;
        return m[source_chan(p)];
    endfunction

    // lowest priority index with its request up
    // -1 when no request is up
    function automatic int priority_winner();
        int winner;
        winner = -1;
        for (int p = 3 * num_channels - 1; p >= 0; p--) begin
            if (source_pending(p)) winner = p;
        end
        return winner;
    endfunction

    // payload over tag for a hit
    // code twice over tag for a marker
    function automatic record_t format_record(input int kind, input int ch, input payload_t data);
        chan_tag_t tag;
        tag = chan_tag_t'(ch + 1);
        if (kind == 0) return {data, tag};
        else if (kind == 1) return {line_code, line_code, tag};
        else return {frame_code, frame_code, tag};
    endfunction

    task automatic expect_equal(input string name, input logic [47:0] got, input logic [47:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, want);
        end
    endtask

    task automatic give_up(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
        $display("checks %0d errors %0d", checks, errors);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // advance one cycle
    // a source drops its request once it saw its done
    task automatic step();
        @(posedge clk);
        #1;
        hit_req   = hit_req & ~last_hit_done;
        line_req  = line_req & ~last_line_done;
        frame_req = frame_req & ~last_frame_done;
    endtask

    task automatic raise_request(input int p);
        int ch;
        ch = source_chan(p);
        case (source_kind(p))
            0: begin
                hit_data[ch*payload_bits +: payload_bits] = $random(seed);
                hit_req[ch] = 1'b1;
            end
            1: line_req[ch] = 1'b1;
            default: frame_req[ch] = 1'b1;
        endcase
    endtask

    task automatic wait_requests_clear(input int limit);
        int cycles;
        cycles = 0;
        while ((hit_req | line_req | frame_req) != '0) begin
            step();
            cycles++;
            if (cycles > limit) give_up("request handshakes");
        end
    endtask

    // queue empty and line idle
    task automatic wait_drained(input int limit);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || tx_busy) begin
            step();
            cycles++;
            if (cycles > limit) give_up("serial drain");
        end
    endtask

    // reference model
    // each done vector against the priority rule
    always @(negedge clk) begin : done_monitor
        int w;
        chan_mask_t exp_hit;
        chan_mask_t exp_line;
        chan_mask_t exp_frame;
        exp_hit   = '0;
        exp_line  = '0;
        exp_frame = '0;
        w = priority_winner();
        if (w >= 0) begin
            case (source_kind(w))
                0: exp_hit[source_chan(w)] = 1'b1;
                1: exp_line[source_chan(w)] = 1'b1;
                default: exp_frame[source_chan(w)] = 1'b1;
            endcase
        end
        if (!rst) begin
            expect_equal("hit_done", hit_done, exp_hit);
            expect_equal("line_done", line_done, exp_line);
            expect_equal("frame_done", frame_done, exp_frame);
            // granted record joins the queue in grant order
            if (w >= 0 && (hit_done | line_done | frame_done) != '0) begin
                exp_q.push_back(format_record(source_kind(w), source_chan(w),
                    hit_data[source_chan(w)*payload_bits +: payload_bits]));
                granted++;
            end
        end
        last_hit_done   = hit_done;
        last_line_done  = line_done;
        last_frame_done = frame_done;
    end

    // serial decoder with mid-bit sampling
    // lowest byte of the record arrives first
    initial begin : serial_decoder
        byte_t   rx_byte;
        record_t rx_record;
        int      byte_idx;
        byte_idx  = 0;
        rx_record = '0;
        forever begin
            @(negedge clk);
            if (!rst && tx === 1'b0) begin
                // first cycle of the start bit
                repeat (clks_per_bit / 2) @(negedge clk);
                expect_equal("tx start bit", tx, 1'b0);
                for (int b = 0; b < 8; b++) begin
                    repeat (clks_per_bit) @(negedge clk);
                    rx_byte[b] = tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                expect_equal("tx stop bit", tx, 1'b1);
                rx_record[8*byte_idx +: 8] = rx_byte;
                byte_idx++;
                if (byte_idx == bytes_per_record) begin
                    byte_idx = 0;
                    decoded++;
                    checks++;
                    assert (exp_q.size() != 0) else begin
                        errors++;
                        $display("record %h arrived on tx with none expected", rx_record);
                    end
                    if (exp_q.size() != 0) expect_equal("tx record", rx_record, exp_q.pop_front());
                end
            end
        end
    end

    initial begin : stimulus
        int p;
        seed      = 32'h79e28b6b;
        checks    = 0;
        errors    = 0;
        granted   = 0;
        decoded   = 0;
        rst       = 1'b1;
        hit_req   = '0;
        line_req  = '0;
        frame_req = '0;
        hit_data  = '0;
        last_hit_done   = '0;
        last_line_done  = '0;
        last_frame_done = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle line after reset
        repeat (4) begin
            @(negedge clk);
            expect_equal("tx", tx, 1'b1);
            expect_equal("tx_busy", tx_busy, 1'b0);
            step();
        end

        // single hits per channel
        for (int ch = 0; ch < num_channels; ch++) begin
            raise_request(ch);
            wait_requests_clear(20);
            wait_drained(1000);
        end
        // single line and frame markers per channel
        for (p = num_channels; p < 3 * num_channels; p++) begin
            raise_request(p);
            wait_requests_clear(20);
            wait_drained(1000);
        end

        // all 18 requests at once
        for (p = 0; p < 3 * num_channels; p++) raise_request(p);
        wait_requests_clear(40);
        wait_drained(18 * 600);

        // random burst with one new request per cycle
        for (int i = 0; i < 20; i++) begin
            step();
            p = $unsigned($random(seed)) % (3 * num_channels);
            while (source_pending(p)) p = (p + 1) % (3 * num_channels);
            raise_request(p);
        end
        wait_requests_clear(40);
        wait_drained(20 * 600);

        // no record left behind the last one
        // the line stays idle
        repeat (2 * clks_per_bit) begin
            @(negedge clk);
            expect_equal("tx_busy", tx_busy, 1'b0);
            expect_equal("tx", tx, 1'b1);
        end
        expect_equal("decoded count", decoded, granted);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/tdc_link_pkg.sv
source/record_arbiter.sv
source/record_fifo.sv
source/uart_tx.sv
source/tdc_link_top.sv
testbench/tdc_link_tb.sv
